// File: sys_master.f
+incdir+hdl
hdl/sys_master_pkg.sv
hdl/rst_sync.sv
hdl/bus_dwidth_converter.sv
hdl/bus_clock_converter.sv
hdl/sys_master.sv
tests/sys_master_assert.sv
tests/tb_sys_master.sv

// File: tests/tb_sys_master.sv
`timescale 1ns/1ns

`include "sys_master_settings.svh"

module tb_sys_master;

    import sys_master_pkg::*;

    localparam int AXI_PERIOD  = 8;
    localparam int MAIN_PERIOD = 20;
    localparam int NUM_TESTS   = 9;

    typedef struct packed {
        bus_op_e    op;
        addr_t      addr;
        host_data_t wdata;
        host_data_t exp;     // Expected read data from the memory image
    } entry_t;

    logic        axi_aclk;
    logic        main_clk;
    logic        arst_n;
    logic        main_rstn;
    logic        host_valid;
    bus_op_e     host_op;
    addr_t       host_addr;
    host_data_t  host_wdata;
    logic        host_ready;
    logic        host_rsp_valid;
    host_data_t  host_rdata;
    logic        m_valid;
    bus_op_e     m_op;
    addr_t       m_addr;
    local_data_t m_wdata;
    logic        m_ready;
    logic        m_rvalid;
    local_data_t m_rdata;

    entry_t      tbl [NUM_TESTS];
    local_data_t mem [addr_t];        // Slave memory
    local_data_t ref_mem [addr_t];    // Expected contents
    bus_op_e     log_op [$];          // Local transfers of the current test
    addr_t       log_addr [$];
    local_data_t log_wdata [$];
    integer      seed = 51;
    int          error_count = 0;
    int          rsp_count = 0;
    int          xfer_count = 0;

    sys_master sys_master_i (
        .axi_aclk_i       ( axi_aclk       ),
        .main_clk_i       ( main_clk       ),
        .arst_n_i         ( arst_n         ),
        .main_rstn_o      ( main_rstn      ),
        .host_valid_i     ( host_valid     ),
        .host_op_i        ( host_op        ),
        .host_addr_i      ( host_addr      ),
        .host_wdata_i     ( host_wdata     ),
        .host_ready_o     ( host_ready     ),
        .host_rsp_valid_o ( host_rsp_valid ),
        .host_rdata_o     ( host_rdata     ),
        .m_valid_o        ( m_valid        ),
        .m_op_o           ( m_op           ),
        .m_addr_o         ( m_addr         ),
        .m_wdata_o        ( m_wdata        ),
        .m_ready_i        ( m_ready        ),
        .m_rvalid_i       ( m_rvalid       ),
        .m_rdata_i        ( m_rdata        )
    );

    bind sys_master sys_master_assert sys_master_assert_u (
        .axi_aclk_i       ( axi_aclk_i                               ),
        .axi_rstn_i       ( axi_rstn                                 ),
        .main_clk_i       ( main_clk_i                               ),
        .main_rstn_i      ( main_rstn_o                              ),
        .host_valid_i     ( host_valid_i                             ),
        .host_ready_i     ( host_ready_o                             ),
        .host_rsp_valid_i ( host_rsp_valid_o                         ),
        .m_valid_i        ( m_valid_o                                ),
        .m_ready_i        ( m_ready_i                                ),
        .m_op_i           ( m_op_o                                   ),
        .m_addr_i         ( m_addr_o                                 ),
        .m_wdata_i        ( m_wdata_o                                ),
        .req_i            ( bus_clock_converter_u.req_q              ),
        .ack_i            ( bus_clock_converter_u.ack_q              ),
        .src_state_i      ( bus_clock_converter_u.src_state_q        ),
        .dst_state_i      ( bus_clock_converter_u.dst_state_q        )
    );

    initial begin
        axi_aclk = 1'b0;
        forever #(AXI_PERIOD/2) axi_aclk = ~axi_aclk;
    end

    initial begin
        main_clk = 1'b0;
        forever #(MAIN_PERIOD/2) main_clk = ~main_clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Contents of a location never written
    function automatic local_data_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a0f_c3e1;
    endfunction

    function automatic local_data_t image_word(addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    task automatic compare_hex(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Value checks plus protocol assertion failures
    function automatic int total_errors();
        return error_count + sys_master_i.sys_master_assert_u.fail_count;
    endfunction

    task automatic set_entry(int idx, bus_op_e op, addr_t addr, host_data_t wdata);
        tbl[idx].op    = op;
        tbl[idx].addr  = addr;
        tbl[idx].wdata = wdata;
        tbl[idx].exp   = '0;
    endtask

    task automatic load_table();
        set_entry(0, OP_WRITE, 32'h0000_0100, 64'h1122_3344_5566_7788);
        set_entry(1, OP_READ,  32'h0000_0100, '0);
        set_entry(2, OP_READ,  32'h0000_02c0, '0);   // Never written
        set_entry(3, OP_WRITE, 32'h0000_0208, 64'hdead_beef_cafe_f00d);
        set_entry(4, OP_WRITE, 32'h0000_03f8, 64'h0123_4567_89ab_cdef);
        set_entry(5, OP_READ,  32'h0000_0208, '0);
        set_entry(6, OP_READ,  32'h0000_03f8, '0);
        set_entry(7, OP_WRITE, 32'h0000_0104, 64'ha5a5_a5a5_5a5a_5a5a);  // Overlaps entry 0
        set_entry(8, OP_READ,  32'h0000_0100, '0);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tbl[i].op == OP_WRITE) begin
                ref_mem[tbl[i].addr]     = tbl[i].wdata[31:0];
                ref_mem[tbl[i].addr + 4] = tbl[i].wdata[63:32];
            end else begin
                tbl[i].exp = {image_word(tbl[i].addr + 4), image_word(tbl[i].addr)};
            end
        end
    endtask

    // One host operation through to its response
    task automatic run_entry(int idx);
        entry_t     e;
        host_data_t got;
        e = tbl[idx];
        log_op.delete();
        log_addr.delete();
        log_wdata.delete();
        @(posedge axi_aclk);
        #1;
        host_valid = 1'b1;
        host_op    = e.op;
        host_addr  = e.addr;
        host_wdata = e.wdata;
        @(negedge axi_aclk);
        while (host_ready !== 1'b1) @(negedge axi_aclk);
        @(posedge axi_aclk);                          // Accepted here
        #1;
        host_valid = 1'b0;
        @(negedge axi_aclk);
        while (host_rsp_valid !== 1'b1) @(negedge axi_aclk);
        got = host_rdata;
        compare_hex("local transfer count", log_op.size(), 2);
        if (log_op.size() == 2) begin
            compare_hex("m_op_o", log_op[0], e.op);
            compare_hex("m_op_o", log_op[1], e.op);
            compare_hex("m_addr_o", log_addr[0], e.addr);
            compare_hex("m_addr_o", log_addr[1], e.addr + `LOCAL_WORD_BYTES);
            if (e.op == OP_WRITE) begin
                compare_hex("m_wdata_o", log_wdata[0], e.wdata[31:0]);
                compare_hex("m_wdata_o", log_wdata[1], e.wdata[63:32]);
            end
        end
        if (e.op == OP_READ) begin
            compare_hex("host_rdata_o", got, e.exp);
        end
    endtask

    //////////////////////////////
    // Slave model
    //////////////////////////////

    always @(negedge axi_aclk) begin
        if (host_rsp_valid === 1'b1) rsp_count++;
    end

    initial begin : slave_model
        logic        xfer;
        logic        hold;
        bus_op_e     x_op;
        addr_t       x_addr;
        local_data_t x_wdata;
        logic        rd_pending;
        addr_t       rd_addr;
        int          rd_delay;
        hold       = 1'b0;
        rd_pending = 1'b0;
        rd_delay   = 0;
        forever begin
            @(negedge main_clk);
            if (hold) begin                           // Stalled on the last edge
                compare_hex("m_valid_o", m_valid, 1'b1);
                compare_hex("m_op_o", m_op, x_op);
                compare_hex("m_addr_o", m_addr, x_addr);
                compare_hex("m_wdata_o", m_wdata, x_wdata);
            end
            xfer    = m_valid && m_ready;
            hold    = m_valid && !m_ready;
            x_op    = m_op;
            x_addr  = m_addr;
            x_wdata = m_wdata;
            @(posedge main_clk);
            #1;
            m_rvalid = 1'b0;
            if (xfer) begin
                xfer_count++;
                log_op.push_back(x_op);
                log_addr.push_back(x_addr);
                log_wdata.push_back(x_wdata);
                if (x_op == OP_WRITE) begin
                    mem[x_addr] = x_wdata;
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = x_addr;
                    rd_delay   = {$random(seed)} % 4;
                end
            end
            if (rd_pending) begin
                if (rd_delay == 0) begin
                    m_rvalid   = 1'b1;
                    m_rdata    = mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
                    rd_pending = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            m_ready = ({$random(seed)} % 4) != 0;     // Stall about one cycle in four
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main_seq
        int errs;
        int fails;
        fails      = 0;
        arst_n     = 1'b0;
        host_valid = 1'b0;
        host_op    = OP_READ;
        host_addr  = '0;
        host_wdata = '0;
        m_ready    = 1'b0;
        m_rvalid   = 1'b0;
        m_rdata    = '0;
        load_table();
        repeat (2) @(posedge axi_aclk);
        #1;
        compare_hex("main_rstn_o", main_rstn, 1'b0);
        arst_n = 1'b1;
        for (int k = 1; k <= 4; k++) begin
            @(posedge main_clk);
            #1;
            compare_hex("main_rstn_o", main_rstn, k == 4);   // High from the fourth edge
        end
        compare_hex("host_ready_o", host_ready, 1'b1);
        compare_hex("m_valid_o", m_valid, 1'b0);

        for (int i = 0; i < NUM_TESTS; i++) begin
            errs = total_errors();
            run_entry(i);
            if (total_errors() != errs) fails++;
            $display("Test %0d %s at %h: %s", i, (tbl[i].op == OP_WRITE) ? "write" : "read",
                     tbl[i].addr, (total_errors() == errs) ? "passed" : "failed");
        end

        repeat (20) @(posedge axi_aclk);
        compare_hex("host response count", rsp_count, NUM_TESTS);
        compare_hex("local transfer total", xfer_count, 2 * NUM_TESTS);
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - fails, fails, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * 200 * AXI_PERIOD);
        $display("Watchdog timeout, the host operations did not complete in time");
        $display("Verification failed");
        $finish;
    end

endmodule : tb_sys_master

// File: tests/sys_master_assert.sv
`timescale 1ns/1ns

module sys_master_assert (
    input  logic                        axi_aclk_i,
    input  logic                        axi_rstn_i,
    input  logic                        main_clk_i,
    input  logic                        main_rstn_i,
    input  logic                        host_valid_i,
    input  logic                        host_ready_i,
    input  logic                        host_rsp_valid_i,
    input  logic                        m_valid_i,
    input  logic                        m_ready_i,
    input  sys_master_pkg::bus_op_e     m_op_i,
    input  sys_master_pkg::addr_t       m_addr_i,
    input  sys_master_pkg::local_data_t m_wdata_i,
    input  logic                        req_i,
    input  logic                        ack_i,
    input  sys_master_pkg::src_state_e  src_state_i,
    input  sys_master_pkg::dst_state_e  dst_state_i
);

    import sys_master_pkg::*;

    logic busy_q;  // Host operation in flight
    int   fail_count = 0;

    always_ff @(posedge axi_aclk_i or negedge axi_rstn_i) begin
        if (!axi_rstn_i) begin
            busy_q <= 1'b0;
        end else if (host_valid_i && host_ready_i) begin
            busy_q <= 1'b1;
        end else if (host_rsp_valid_i) begin
            busy_q <= 1'b0;
        end
    end

    //////////////////////////////
    // Host and local ports
    //////////////////////////////

    m_hold_a: assert property (@(posedge main_clk_i) disable iff (!main_rstn_i)
        m_valid_i && !m_ready_i |=>
            m_valid_i && $stable(m_op_i) && $stable(m_addr_i) && $stable(m_wdata_i))
        else begin
            $error("Local master request changed under back-pressure");
            fail_count++;
        end

    host_busy_a: assert property (@(posedge axi_aclk_i) disable iff (!axi_rstn_i)
        busy_q |-> !host_ready_i)
        else begin
            $error("host_ready_o high while an operation is in flight");
            fail_count++;
        end

    //////////////////////////////
    // Four-phase req/ack
    //////////////////////////////

    req_rise_a: assert property (@(posedge axi_aclk_i) disable iff (!axi_rstn_i)
        $rose(req_i) |-> !ack_i)
        else begin
            $error("req raised while ack still high");
            fail_count++;
        end

    req_fall_a: assert property (@(posedge axi_aclk_i) disable iff (!axi_rstn_i)
        $fell(req_i) |-> ack_i)
        else begin
            $error("req dropped before ack");
            fail_count++;
        end

    // Source only takes a new operation once ack is back low
    src_idle_a: assert property (@(posedge axi_aclk_i) disable iff (!axi_rstn_i)
        (src_state_i == SRC_IDLE) |-> !ack_i)
        else begin
            $error("Source idle while ack still high");
            fail_count++;
        end

    ack_rise_a: assert property (@(posedge main_clk_i) disable iff (!main_rstn_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack raised without req");
            fail_count++;
        end

    ack_fall_a: assert property (@(posedge main_clk_i) disable iff (!main_rstn_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            $error("ack dropped while req still high");
            fail_count++;
        end

    dst_busy_a: assert property (@(posedge main_clk_i) disable iff (!main_rstn_i)
        (dst_state_i == DST_XFER || dst_state_i == DST_RWAIT) |-> req_i)
        else begin
            $error("Local transfer running while req is low");
            fail_count++;
        end

endmodule : sys_master_assert

// File: hdl/sys_master.sv
`timescale 1ns/1ns

module sys_master (
    // Clocks and the one asynchronous reset
    input  logic                        axi_aclk_i,
    input  logic                        main_clk_i,
    input  logic                        arst_n_i,
    output logic                        main_rstn_o,

    // Host port, axi_aclk domain
    input  logic                        host_valid_i,
    input  sys_master_pkg::bus_op_e     host_op_i,
    input  sys_master_pkg::addr_t       host_addr_i,
    input  sys_master_pkg::host_data_t  host_wdata_i,
    output logic                        host_ready_o,
    output logic                        host_rsp_valid_o,
    output sys_master_pkg::host_data_t  host_rdata_o,

    // Local master port, main_clk domain
    output logic                        m_valid_o,
    output sys_master_pkg::bus_op_e     m_op_o,
    output sys_master_pkg::addr_t       m_addr_o,
    output sys_master_pkg::local_data_t m_wdata_o,
    input  logic                        m_ready_i,
    input  logic                        m_rvalid_i,
    input  sys_master_pkg::local_data_t m_rdata_i
);

    import sys_master_pkg::*;

    logic        axi_rstn;

    // Width converter to clock converter
    logic        loc_valid;
    bus_op_e     loc_op;
    addr_t       loc_addr;
    local_data_t loc_wdata;
    logic        loc_ready;
    logic        loc_done;
    local_data_t loc_rdata;

    //////////////////////////////
    // Reset synchronizers
    //////////////////////////////

    rst_sync axi_rst_sync_u (
        .clk_i    ( axi_aclk_i ),
        .arst_n_i ( arst_n_i   ),
        .rst_n_o  ( axi_rstn   )
    );

    rst_sync main_rst_sync_u (
        .clk_i    ( main_clk_i  ),
        .arst_n_i ( arst_n_i    ),
        .rst_n_o  ( main_rstn_o )
    );

    //////////////////////////////
    // Converter chain
    //////////////////////////////

    bus_dwidth_converter bus_dwidth_converter_u (
        .axi_aclk_i       ( axi_aclk_i       ),
        .axi_rstn_i       ( axi_rstn         ),
        .host_valid_i     ( host_valid_i     ),
        .host_op_i        ( host_op_i        ),
        .host_addr_i      ( host_addr_i      ),
        .host_wdata_i     ( host_wdata_i     ),
        .host_ready_o     ( host_ready_o     ),
        .host_rsp_valid_o ( host_rsp_valid_o ),
        .host_rdata_o     ( host_rdata_o     ),
        .loc_valid_o      ( loc_valid        ),
        .loc_op_o         ( loc_op           ),
        .loc_addr_o       ( loc_addr         ),
        .loc_wdata_o      ( loc_wdata        ),
        .loc_ready_i      ( loc_ready        ),
        .loc_done_i       ( loc_done         ),
        .loc_rdata_i      ( loc_rdata        )
    );

    bus_clock_converter bus_clock_converter_u (
        .axi_aclk_i  ( axi_aclk_i  ),
        .axi_rstn_i  ( axi_rstn    ),
        .main_clk_i  ( main_clk_i  ),
        .main_rstn_i ( main_rstn_o ),  // Same synchronized reset as the output
        .loc_valid_i ( loc_valid   ),
        .loc_op_i    ( loc_op      ),
        .loc_addr_i  ( loc_addr    ),
        .loc_wdata_i ( loc_wdata   ),
        .loc_ready_o ( loc_ready   ),
        .loc_done_o  ( loc_done    ),
        .loc_rdata_o ( loc_rdata   ),
        .m_valid_o   ( m_valid_o   ),
        .m_op_o      ( m_op_o      ),
        .m_addr_o    ( m_addr_o    ),
        .m_wdata_o   ( m_wdata_o   ),
        .m_ready_i   ( m_ready_i   ),
        .m_rvalid_i  ( m_rvalid_i  ),
        .m_rdata_i   ( m_rdata_i   )
    );

endmodule : sys_master

// File: hdl/bus_clock_converter.sv
`timescale 1ns/1ns

module bus_clock_converter (
    input  logic                        axi_aclk_i,
    input  logic                        axi_rstn_i,
    input  logic                        main_clk_i,
    input  logic                        main_rstn_i,

    // Local port, axi_aclk domain
    input  logic                        loc_valid_i,
    input  sys_master_pkg::bus_op_e     loc_op_i,
    input  sys_master_pkg::addr_t       loc_addr_i,
    input  sys_master_pkg::local_data_t loc_wdata_i,
    output logic                        loc_ready_o,
    output logic                        loc_done_o,
    output sys_master_pkg::local_data_t loc_rdata_o,

    // Master port, main_clk domain
    output logic                        m_valid_o,
    output sys_master_pkg::bus_op_e     m_op_o,
    output sys_master_pkg::addr_t       m_addr_o,
    output sys_master_pkg::local_data_t m_wdata_o,
    input  logic                        m_ready_i,
    input  logic                        m_rvalid_i,
    input  sys_master_pkg::local_data_t m_rdata_i
);

    import sys_master_pkg::*;

    // Source side, axi_aclk
    src_state_e  src_state_q;
    logic        req_q;
    logic        ack_meta_q;
    logic        ack_sync_q;
    logic        done_q;
    bus_op_e     src_op_q;
    addr_t       src_addr_q;
    local_data_t src_wdata_q;
    local_data_t src_rdata_q;

    // Destination side, main_clk
    dst_state_e  dst_state_q;
    logic        req_meta_q;
    logic        req_sync_q;
    logic        ack_q;
    local_data_t dst_rdata_q;

    //////////////////////////////
    // Source side
    //////////////////////////////

    assign loc_ready_o = (src_state_q == SRC_IDLE);  // Only once ack is back low

    always_ff @(posedge axi_aclk_i or negedge axi_rstn_i) begin
        if (!axi_rstn_i) begin
            src_state_q <= SRC_IDLE;
            req_q       <= 1'b0;
            ack_meta_q  <= 1'b0;
            ack_sync_q  <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            ack_meta_q <= ack_q;
            ack_sync_q <= ack_meta_q;
            done_q     <= 1'b0;
            case (src_state_q)
                SRC_IDLE: if (loc_valid_i) begin
                    req_q       <= 1'b1;
                    src_state_q <= SRC_REQ;
                end
                SRC_REQ: if (ack_sync_q) begin
                    req_q       <= 1'b0;
                    done_q      <= 1'b1;
                    src_state_q <= SRC_DROP;
                end
                SRC_DROP: if (!ack_sync_q) src_state_q <= SRC_IDLE;
                default: src_state_q <= SRC_IDLE;
            endcase
        end
    end

    // Held steady while req is high, read directly by main_clk side
    always_ff @(posedge axi_aclk_i) begin
        if (loc_valid_i && loc_ready_o) begin
            src_op_q    <= loc_op_i;
            src_addr_q  <= loc_addr_i;
            src_wdata_q <= loc_wdata_i;
        end
        if (src_state_q == SRC_REQ && ack_sync_q) begin
            src_rdata_q <= dst_rdata_q;   // Stable while ack is high
        end
    end

    assign loc_done_o  = done_q;
    assign loc_rdata_o = src_rdata_q;

    //////////////////////////////
    // Destination side
    //////////////////////////////

    always_ff @(posedge main_clk_i or negedge main_rstn_i) begin
        if (!main_rstn_i) begin
            dst_state_q <= DST_IDLE;
            req_meta_q  <= 1'b0;
            req_sync_q  <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            req_meta_q <= req_q;
            req_sync_q <= req_meta_q;
            case (dst_state_q)
                DST_IDLE: if (req_sync_q) dst_state_q <= DST_XFER;
                DST_XFER: if (m_ready_i) begin
                    if (src_op_q == OP_WRITE) begin
                        ack_q       <= 1'b1;      // Write done at transfer
                        dst_state_q <= DST_ACK;
                    end else begin
                        dst_state_q <= DST_RWAIT;
                    end
                end
                DST_RWAIT: if (m_rvalid_i) begin
                    ack_q       <= 1'b1;
                    dst_state_q <= DST_ACK;
                end
                DST_ACK: if (!req_sync_q) begin
                    ack_q       <= 1'b0;
                    dst_state_q <= DST_IDLE;
                end
                default: dst_state_q <= DST_IDLE;
            endcase
        end
    end

    always_ff @(posedge main_clk_i) begin
        if (dst_state_q == DST_RWAIT && m_rvalid_i) begin
            dst_rdata_q <= m_rdata_i;
        end
    end

    assign m_valid_o = (dst_state_q == DST_XFER);
    assign m_op_o    = src_op_q;
    assign m_addr_o  = src_addr_q;
    assign m_wdata_o = src_wdata_q;

endmodule : bus_clock_converter

// File: hdl/bus_dwidth_converter.sv
`timescale 1ns/1ns

`include "sys_master_settings.svh"

module bus_dwidth_converter (
    input  logic                        axi_aclk_i,
    input  logic                        axi_rstn_i,

    // Host port, 64 bit
    input  logic                        host_valid_i,
    input  sys_master_pkg::bus_op_e     host_op_i,
    input  sys_master_pkg::addr_t       host_addr_i,
    input  sys_master_pkg::host_data_t  host_wdata_i,
    output logic                        host_ready_o,
    output logic                        host_rsp_valid_o,
    output sys_master_pkg::host_data_t  host_rdata_o,

    // Local port, 32 bit
    output logic                        loc_valid_o,
    output sys_master_pkg::bus_op_e     loc_op_o,
    output sys_master_pkg::addr_t       loc_addr_o,
    output sys_master_pkg::local_data_t loc_wdata_o,
    input  logic                        loc_ready_i,
    input  logic                        loc_done_i,
    input  sys_master_pkg::local_data_t loc_rdata_i
);

    import sys_master_pkg::*;

    dw_state_e   state_q;
    logic        loc_valid_q;
    logic        rsp_valid_q;

    // Captured host operation
    bus_op_e     op_q;
    addr_t       addr_q;
    host_data_t  wdata_q;
    local_data_t rdata_lo_q;
    host_data_t  rdata_q;

    logic        host_fire;
    logic        loc_fire;
    logic        high_half;

    assign host_fire = host_valid_i && host_ready_o;
    assign loc_fire  = loc_valid_o && loc_ready_i;
    assign high_half = (state_q == DW_HIGH);

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge axi_aclk_i or negedge axi_rstn_i) begin
        if (!axi_rstn_i) begin
            state_q     <= DW_IDLE;
            loc_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;                      // One cycle pulse
            if (loc_fire) begin
                loc_valid_q <= 1'b0;
            end
            case (state_q)
                DW_IDLE: begin
                    if (host_fire) begin
                        state_q     <= DW_LOW;
                        loc_valid_q <= 1'b1;
                    end
                end
                DW_LOW: begin
                    if (loc_done_i) begin
                        state_q     <= DW_HIGH;        // Now the upper word
                        loc_valid_q <= 1'b1;
                    end
                end
                DW_HIGH: begin
                    if (loc_done_i) begin
                        state_q     <= DW_IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= DW_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge axi_aclk_i) begin
        if (host_fire) begin
            op_q    <= host_op_i;
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
        end
        if (loc_done_i && state_q == DW_LOW) begin
            rdata_lo_q <= loc_rdata_i;
        end
        if (loc_done_i && high_half) begin
            rdata_q <= {loc_rdata_i, rdata_lo_q};     // Merge both halves
        end
    end

    assign loc_valid_o = loc_valid_q;
    assign loc_op_o    = op_q;
    assign loc_addr_o  = high_half ? addr_q + addr_t'(`LOCAL_WORD_BYTES) : addr_q;
    assign loc_wdata_o = high_half ? wdata_q[`HOST_DATA_WIDTH-1:`LOCAL_DATA_WIDTH]
                                   : wdata_q[`LOCAL_DATA_WIDTH-1:0];

    // Ready comes back the cycle after the response
    assign host_ready_o     = (state_q == DW_IDLE) && !rsp_valid_q;
    assign host_rsp_valid_o = rsp_valid_q;
    assign host_rdata_o     = rdata_q;

endmodule : bus_dwidth_converter

// File: hdl/rst_sync.sv
`timescale 1ns/1ns

`include "sys_master_settings.svh"

module rst_sync #(
    parameter int unsigned STAGES = `RST_SYNC_STAGES
) (
    input  logic clk_i,
    input  logic arst_n_i,
    output logic rst_n_o
);

    logic [STAGES-1:0] sync_q;

    // Assert at once, release through the chain
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], 1'b1};  // Shift ones in
        end
    end

    assign rst_n_o = sync_q[STAGES-1];

endmodule : rst_sync

// File: hdl/sys_master_pkg.sv
`include "sys_master_settings.svh"

package sys_master_pkg;

    // Bus payload types
    typedef logic [`SYS_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`HOST_DATA_WIDTH-1:0]  host_data_t;
    typedef logic [`LOCAL_DATA_WIDTH-1:0] local_data_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Width converter: which half is in flight
    typedef enum logic [1:0] {
        DW_IDLE,
        DW_LOW,
        DW_HIGH
    } dw_state_e;

    // Clock converter, axi_aclk side
    typedef enum logic [1:0] {
        SRC_IDLE,
        SRC_REQ,   // req high, waiting for ack
        SRC_DROP   // req low, waiting for ack to fall
    } src_state_e;

    // Clock converter, main_clk side
    typedef enum logic [1:0] {
        DST_IDLE,
        DST_XFER,
        DST_RWAIT,
        DST_ACK
    } dst_state_e;

endpackage : sys_master_pkg

// File: hdl/sys_master_settings.svh
`ifndef SYS_MASTER_SETTINGS_SVH
`define SYS_MASTER_SETTINGS_SVH

// Byte address width on both buses
`define SYS_ADDR_WIDTH 32

// Host side word, as seen in the axi_aclk domain
`define HOST_DATA_WIDTH 64

// Local master word, main_clk domain
`define LOCAL_DATA_WIDTH 32

// Flops per reset synchronizer
`define RST_SYNC_STAGES 4

// Address step from the low half to the high half
`define LOCAL_WORD_BYTES 4

`endif
